// ==== hw/rvPkg.sv ====
`default_nettype none

package rvPkg;

    // Opcodes of the supported subset
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4
    } aluOpT;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2   // Link value for jal and jalr
    } resultSrcT;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } immSrcT;

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_BYTES = 256;

    // Top two bits of the APB address
    localparam logic [1:0] APB_REGION_IMEM = 2'd0;
    localparam logic [1:0] APB_REGION_DMEM = 2'd1;
    localparam logic [1:0] APB_REGION_REGS = 2'd2;

endpackage

`default_nettype wire

// ==== hw/coreIfs.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;
    import rvPkg::*;

    logic [31:0] instr;
    logic        eq;
    logic        regWrite;
    aluOpT       aluOp;
    logic        aluSrc;     // Immediate as operand b
    immSrcT      immSrc;
    logic        jump;
    logic        jumpReg;    // jalr target from the ALU
    logic        branch;     // Branch taken
    logic        memWrite;
    logic        memRead;
    resultSrcT   resultSrc;
    logic        ebreak;

    modport decoder (
        input  instr, eq,
        output regWrite, aluOp, aluSrc, immSrc, jump, jumpReg, branch,
        output memWrite, memRead, resultSrc, ebreak
    );

    modport datapath (
        output instr, eq,
        input  regWrite, aluOp, aluSrc, immSrc, jump, jumpReg, branch,
        input  memWrite, memRead, resultSrc, ebreak
    );
endinterface

interface dataBusIf;
    logic [7:0] addr;
    logic [7:0] wdata;
    logic       write;
    logic       read;
    logic [7:0] rdata;

    modport master (output addr, wdata, write, read, input rdata);
    modport slave  (input addr, wdata, write, read, output rdata);
endinterface

`default_nettype wire

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    ctrlIf.decoder ctrl
);
    import rvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = ctrl.instr[6:0];
    assign funct3 = ctrl.instr[14:12];
    assign funct7 = ctrl.instr[31:25];

    always_comb begin
        ctrl.regWrite  = 1'b0;
        ctrl.aluOp     = ALU_ADD;
        ctrl.aluSrc    = 1'b0;
        ctrl.immSrc    = IMM_I;
        ctrl.jump      = 1'b0;
        ctrl.jumpReg   = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.memRead   = 1'b0;
        ctrl.resultSrc = RES_ALU;
        ctrl.ebreak    = 1'b0;

        case (opcode)
            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_J;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = RES_PC4;
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrc    = 1'b1;   // rs1 + imm
                    ctrl.jump      = 1'b1;
                    ctrl.jumpReg   = 1'b1;
                    ctrl.resultSrc = RES_PC4;
                end
            end
            OP_OPIMM: begin
                if (funct3 == 3'b000) begin   // addi only
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b000) begin   // sb
                    ctrl.aluSrc   = 1'b1;
                    ctrl.immSrc   = IMM_S;
                    ctrl.memWrite = 1'b1;
                end
            end
            OP_LOAD: begin
                if (funct3 == 3'b100) begin   // lbu
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrc    = 1'b1;
                    ctrl.memRead   = 1'b1;
                    ctrl.resultSrc = RES_MEM;
                end
            end
            OP_BRANCH: begin
                if (funct3 == 3'b001) begin   // bne
                    ctrl.aluOp  = ALU_SUB;
                    ctrl.immSrc = IMM_B;
                    ctrl.branch = ~ctrl.eq;
                end
            end
            OP_AUIPC: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = IMM_U;    // Datapath puts pc on operand a
            end
            OP_OP: begin
                ctrl.regWrite = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.aluOp = ALU_ADD;
                    {7'h20, 3'b000}: ctrl.aluOp = ALU_SUB;
                    {7'h00, 3'b111}: ctrl.aluOp = ALU_AND;
                    {7'h00, 3'b110}: ctrl.aluOp = ALU_OR;
                    {7'h00, 3'b010}: ctrl.aluOp = ALU_SLT;
                    default:         ctrl.regWrite = 1'b0;
                endcase
            end
            OP_SYSTEM: begin
                // Only ebreak, every other field zero
                ctrl.ebreak = (ctrl.instr[31:7] == 25'h0002000);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  wire logic [31:0] a,
    input  wire logic [31:0] b,
    input  wire rvPkg::aluOpT op,
    output logic [31:0]      y,
    output logic             eq
);
    import rvPkg::*;

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_SLT: y = {31'b0, $signed(a) < $signed(b)};
            default: y = '0;
        endcase
    end

    assign eq = (a == b);   // Used by bne

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        we,
    input  wire logic [4:0]  rs1,
    input  wire logic [4:0]  rs2,
    input  wire logic [4:0]  rd,
    input  wire logic [4:0]  dbgAddr,
    input  wire logic [31:0] wd,
    output logic [31:0]      rd1,
    output logic [31:0]      rd2,
    output logic [31:0]      dbgData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1     = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2     = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign dbgData = (dbgAddr == 5'd0) ? '0 : regs[dbgAddr];   // Host view over APB

endmodule

`default_nettype wire

// ==== hw/coreDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreDatapath (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        run,
    output logic             halted,
    ctrlIf.datapath          ctrl,
    dataBusIf.master         dbus,
    output logic [31:0]      pc,
    input  wire logic [31:0] instr,
    input  wire logic [4:0]  dbgAddr,
    output logic [31:0]      dbgData
);
    import rvPkg::*;

    logic [31:0] imm;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] aluY;
    logic        aluEq;
    logic [31:0] result;
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;
    logic [31:0] pcNext;
    logic        advance;

    assign ctrl.instr = instr;
    assign ctrl.eq    = aluEq;

    always_comb begin
        case (ctrl.immSrc)
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'b0};
            IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    assign srcA = (ctrl.immSrc == IMM_U) ? pc : rd1;   // auipc
    assign srcB = ctrl.aluSrc ? imm : rd2;

    regFile uRegs (
        .clk     (clk),
        .reset   (reset),
        .we      (ctrl.regWrite && advance),
        .rs1     (instr[19:15]),
        .rs2     (instr[24:20]),
        .rd      (instr[11:7]),
        .dbgAddr (dbgAddr),
        .wd      (result),
        .rd1     (rd1),
        .rd2     (rd2),
        .dbgData (dbgData)
    );

    aluUnit uAlu (
        .a  (srcA),
        .b  (srcB),
        .op (ctrl.aluOp),
        .y  (aluY),
        .eq (aluEq)
    );

    assign dbus.addr  = aluY[7:0];
    assign dbus.wdata = rd2[7:0];
    assign dbus.write = ctrl.memWrite && advance;
    assign dbus.read  = ctrl.memRead;

    always_comb begin
        case (ctrl.resultSrc)
            RES_MEM: result = {24'b0, dbus.rdata};   // lbu zero-extends
            RES_PC4: result = pcPlus4;
            default: result = aluY;
        endcase
    end

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = ctrl.jumpReg ? {aluY[31:1], 1'b0} : pc + imm;
    assign pcNext   = (ctrl.jump || ctrl.branch) ? pcTarget : pcPlus4;
    assign advance  = run && !halted;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (advance) begin
            if (ctrl.ebreak)
                halted <= 1'b1;   // pc holds on the ebreak
            else
                pc <= pcNext & 32'(IMEM_WORDS * 4 - 1);   // Wraps inside instruction memory
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hw/memApb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memApb (
    input  wire logic        clk,
    input  wire logic [31:0] fetchPc,
    output logic [31:0]      fetchInstr,
    dataBusIf.slave          dbus,
    input  wire logic        busy,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [11:0] paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic [4:0]       regDbgAddr,
    input  wire logic [31:0] regDbgData
);
    import rvPkg::*;

    logic [31:0] imem [IMEM_WORDS];
    logic [7:0]  dmem [DMEM_BYTES];
    logic [1:0]  region;
    logic        access;
    logic        memRegion;
    logic        writeErr;
    logic        hostWrite;

    assign region    = paddr[11:10];
    assign access    = psel && penable;
    assign memRegion = (region == APB_REGION_IMEM) || (region == APB_REGION_DMEM);
    assign writeErr  = pwrite && ((region == APB_REGION_REGS) || (busy && memRegion));
    assign hostWrite = access && pwrite && !writeErr;

    assign fetchInstr = imem[fetchPc[2 +: $clog2(IMEM_WORDS)]];
    assign dbus.rdata = dbus.read ? dmem[dbus.addr] : 8'h00;   // 8-bit address wraps

    always_ff @(posedge clk) begin
        if (hostWrite && region == APB_REGION_IMEM)
            imem[paddr[2 +: $clog2(IMEM_WORDS)]] <= pwdata;
    end

    // Core and host never write in the same cycle
    always_ff @(posedge clk) begin
        if (dbus.write)
            dmem[dbus.addr] <= dbus.wdata;
        else if (hostWrite && region == APB_REGION_DMEM)
            dmem[paddr[7:0]] <= pwdata[7:0];
    end

    assign regDbgAddr = paddr[6:2];   // Word-addressed like imem

    always_comb begin
        case (region)
            APB_REGION_IMEM: prdata = imem[paddr[2 +: $clog2(IMEM_WORDS)]];
            APB_REGION_DMEM: prdata = {24'b0, dmem[paddr[7:0]]};
            APB_REGION_REGS: prdata = regDbgData;
            default:         prdata = '0;
        endcase
    end

    assign pready  = 1'b1;
    assign pslverr = access && writeErr;

    penableWithPsel: assert property (@(posedge clk) penable |-> psel);

    noWriteClash: assert property (@(posedge clk)
        dbus.write |-> !(hostWrite && region == APB_REGION_DMEM));

endmodule

`default_nettype wire

// ==== hw/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        run,
    output logic             halted,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [11:0] paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr
);

    logic [31:0] pc;
    logic [31:0] instr;
    logic [4:0]  dbgAddr;
    logic [31:0] dbgData;
    logic        busy;

    ctrlIf    ctrlBus ();
    dataBusIf dataBus ();

    assign busy = run && !halted;   // Blocks host memory writes

    controlUnit uDecoder (
        .ctrl (ctrlBus.decoder)
    );

    coreDatapath uCore (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .halted  (halted),
        .ctrl    (ctrlBus.datapath),
        .dbus    (dataBus.master),
        .pc      (pc),
        .instr   (instr),
        .dbgAddr (dbgAddr),
        .dbgData (dbgData)
    );

    memApb uMem (
        .clk        (clk),
        .fetchPc    (pc),
        .fetchInstr (instr),
        .dbus       (dataBus.slave),
        .busy       (busy),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .regDbgAddr (dbgAddr),
        .regDbgData (dbgData)
    );

endmodule

`default_nettype wire

// ==== test/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [31:0] lfsrState = 32'hb3c6_dfd0;
logic [31:0] prog [IMEM_WORDS];
logic [31:0] mRegs [32];
logic [7:0]  mMem [DMEM_BYTES];

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        v         = {v[30:0], fb};
    end
    return v;
endfunction

function automatic int randRange(int lo, int hi);
    return lo + int'(randBits(16)) % (hi - lo + 1);
endfunction

function automatic logic [31:0] encR(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                     logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP_OP};
endfunction

function automatic logic [31:0] encI(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                     logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2);
    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// 40 random instructions, then ebreak at word 40
function automatic void buildProgram();
    int         kind;
    int         target;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    for (int w = 0; w < IMEM_WORDS; w++)
        prog[w] = 32'h00100073;   // ebreak
    for (int i = 0; i < 40; i++) begin
        kind   = randRange(0, 11);
        rd     = 5'(randBits(5));
        rs1    = 5'(randBits(5));
        rs2    = 5'(randBits(5));
        target = randRange(i + 1, 40);   // Forward only
        case (kind)
            0: prog[i] = encI(OP_OPIMM, 3'b000, rd, rs1, 12'(randBits(12)));
            1: prog[i] = encR(7'h00, 3'b000, rd, rs1, rs2);
            2: prog[i] = encR(7'h20, 3'b000, rd, rs1, rs2);
            3: prog[i] = encR(7'h00, 3'b111, rd, rs1, rs2);
            4: prog[i] = encR(7'h00, 3'b110, rd, rs1, rs2);
            5: prog[i] = encR(7'h00, 3'b010, rd, rs1, rs2);
            6: prog[i] = encS(12'(randRange(0, 255)), rs2, 5'd0);
            7: prog[i] = encI(OP_LOAD, 3'b100, rd, 5'd0, 12'(randRange(0, 255)));
            8: prog[i] = {20'(randBits(20)), rd, OP_AUIPC};
            9: prog[i] = encJ(21'((target - i) * 4), rd);
            10: prog[i] = encI(OP_JALR, 3'b000, rd, 5'd0, 12'(target * 4));
            default: prog[i] = encB(13'((target - i) * 4), rs1, rs2);
        endcase
    end
endfunction

// Reference ISA execution on mRegs and mMem
function automatic void runModel();
    logic [31:0] mPc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] wv;
    logic [31:0] nextPc;
    logic [7:0]  addr;
    logic        wr;
    mPc = '0;
    for (int step = 0; step < 1000; step++) begin
        ins = prog[mPc[7:2]];
        if (ins == 32'h00100073)
            break;
        a      = mRegs[ins[19:15]];
        b      = mRegs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        wv     = mPc + 32'd4;   // Link value unless replaced
        wr     = 1'b1;
        nextPc = mPc + 32'd4;
        case (ins[6:0])
            OP_OPIMM: wv = a + immI;
            OP_OP: begin
                case ({ins[30], ins[14:12]})
                    4'b0000: wv = a + b;
                    4'b1000: wv = a - b;
                    4'b0111: wv = a & b;
                    4'b0110: wv = a | b;
                    default: wv = {31'b0, $signed(a) < $signed(b)};
                endcase
            end
            OP_STORE: begin
                addr       = 8'(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
                mMem[addr] = b[7:0];
                wr         = 1'b0;
            end
            OP_LOAD: begin
                addr = 8'(a + immI);
                wv   = {24'b0, mMem[addr]};
            end
            OP_AUIPC: wv = mPc + {ins[31:12], 12'b0};
            OP_JAL: nextPc = mPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            OP_JALR: nextPc = (a + immI) & ~32'd1;
            default: begin   // bne
                wr = 1'b0;
                if (a != b)
                    nextPc = mPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
        endcase
        if (wr && ins[11:7] != 5'd0)
            mRegs[ins[11:7]] = wv;
        mPc = nextPc & 32'hff;
    end
endfunction

`endif

// ==== test/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
    import rvPkg::*;

    logic        clk;
    logic        reset;
    logic        run;
    logic        halted;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    `include "isaModel.svh"

    cpuTop uut (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .halted  (halted),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic abortRun(input string why);
        $display("ERROR: %s", why);
        failRun();
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            failRun();
        end
    endtask

    function automatic logic [11:0] imemAddr(int w);
        return {APB_REGION_IMEM, 2'b00, 6'(w), 2'b00};
    endfunction

    function automatic logic [11:0] dmemAddr(int b);
        return {APB_REGION_DMEM, 2'b00, 8'(b)};
    endfunction

    function automatic logic [11:0] regAddr(int r);
        return {APB_REGION_REGS, 3'b000, 5'(r), 2'b00};
    endfunction

    // Setup phase, then a single access phase
    task automatic apbTransfer(input logic write, input logic [11:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        checkValue("pready", 32'(pready), 32'd1);   // Zero wait states
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data,
                            input logic expErr);
        logic [31:0] unused;
        logic        err;
        apbTransfer(1'b1, addr, data, unused, err);
        checkValue("pslverr", 32'(err), 32'(expErr));
    endtask

    task automatic apbRead(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        apbTransfer(1'b0, addr, 32'h0, data, err);
        checkValue("pslverr", 32'(err), 32'd0);
    endtask

    task automatic resetCore();
        @(posedge clk);
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue("halted", 32'(halted), 32'd0);
        for (int r = 0; r < 32; r++)
            mRegs[r] = '0;
    endtask

    task automatic checkRegisters();
        logic [31:0] data;
        for (int r = 1; r < 32; r++) begin
            apbRead(regAddr(r), data);
            checkValue($sformatf("x%0d", r), data, mRegs[r]);
        end
    endtask

    task automatic fillDataMem();
        for (int b = 0; b < DMEM_BYTES; b++) begin
            mMem[b] = 8'(randBits(8));
            apbWrite(dmemAddr(b), {24'(randBits(24)), mMem[b]}, 1'b0);
        end
    endtask

    task automatic checkDataMem();
        logic [31:0] data;
        for (int b = 0; b < DMEM_BYTES; b++) begin
            apbRead(dmemAddr(b), data);
            checkValue($sformatf("dmem[0x%02h]", b), data, {24'b0, mMem[b]});
        end
    endtask

    task automatic loadProgram();
        for (int w = 0; w < IMEM_WORDS; w++)
            apbWrite(imemAddr(w), prog[w], 1'b0);
    endtask

    task automatic checkProgram();
        logic [31:0] data;
        for (int w = 0; w < IMEM_WORDS; w++) begin
            apbRead(imemAddr(w), data);
            checkValue($sformatf("imem[%0d]", w), data, prog[w]);
        end
    endtask

    task automatic waitHalted();
        int cycles;
        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2000)
                abortRun("halted did not rise within 2000 cycles");
        end
    endtask

    // Writes refused while the core spins on jal x0, 0
    task automatic checkIllegalWrites();
        logic [31:0] data;
        apbWrite(imemAddr(0), 32'h0000006f, 1'b0);
        @(posedge clk);
        run <= 1'b1;
        apbWrite(imemAddr(0), 32'h00100073, 1'b1);
        apbWrite(dmemAddr(7), {24'b0, ~mMem[7]}, 1'b1);
        apbWrite(regAddr(3), 32'hdead_beef, 1'b1);
        apbRead(imemAddr(0), data);
        checkValue("imem[0]", data, 32'h0000006f);
        apbRead(dmemAddr(7), data);
        checkValue("dmem[0x07]", data, {24'b0, mMem[7]});
        checkValue("halted", 32'(halted), 32'd0);
        @(posedge clk);
        run <= 1'b0;
        apbWrite(regAddr(3), 32'h1234_5678, 1'b1);   // Refused even when idle
        apbRead(regAddr(3), data);
        checkValue("x3", data, 32'h0);
    endtask

    task automatic runProgram();
        resetCore();
        buildProgram();
        loadProgram();
        fillDataMem();
        runModel();
        @(posedge clk);
        run <= 1'b1;
        waitHalted();
        checkRegisters();
        checkDataMem();
        repeat (20) begin
            @(negedge clk);
            checkValue("halted", 32'(halted), 32'd1);
        end
        checkRegisters();
        @(posedge clk);
        run <= 1'b0;
    endtask

    initial begin
        reset   = 1'b1;
        run     = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;

        resetCore();
        checkRegisters();

        for (int w = 0; w < IMEM_WORDS; w++)
            prog[w] = randBits(32);
        loadProgram();
        checkProgram();
        fillDataMem();
        checkDataMem();

        checkIllegalWrites();

        for (int p = 0; p < 8; p++)
            runProgram();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+test
hw/rvPkg.sv
hw/coreIfs.sv
hw/controlUnit.sv
hw/aluUnit.sv
hw/regFile.sv
hw/coreDatapath.sv
hw/memApb.sv
hw/cpuTop.sv
test/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cpuTb \
    -Mdir obj_dir -o cpuTbSim > build.log 2>&1 \
    && ./obj_dir/cpuTbSim > sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
